//--- sim.f
+incdir+verification
src/fetch_pkg.sv
src/thread_queue.sv
src/thread_arbiter.sv
src/slot_decoder.sv
src/bundle_decoder.sv
src/fetch_top.sv
verification/fetch_assertions.sv
verification/tb_fetch_top.sv

//--- verification/fetch_model.svh
// cycle model of both queues, the thread register and the decode rules
localparam int depth = 8;
localparam logic [15:0] reset_ip = 16'h0100;

logic [15:0] mq [2][depth];
int          mcount [2];
logic [15:0] mip [2];
logic        mthread;
int          lost_fills;

// what the slots should show one cycle later
logic        exp_en [2];
logic        exp_thread;
logic [15:0] exp_ip [2];
logic [15:0] exp_instr [2];

task automatic clear_state();
  for (int t = 0; t < 2; t++) begin
    mcount[t] = 0;
    mip[t] = reset_ip;
    exp_en[t] = 1'b0;
    for (int i = 0; i < depth; i++) begin
      mq[t][i] = '0;
    end
  end
  mthread = 1'b0;
  lost_fills = 0;
endtask

// op, port, rt, ra, rb, rt_use, use_const, constant
function automatic logic [35:0] decode_fields(input logic [15:0] instr);
  logic [3:0]  opc;
  logic [3:0]  op;
  logic [1:0]  port;
  logic        rt_use;
  logic        use_const;
  logic [15:0] cval;
  opc = instr[15:12];
  op = (opc > 4'd11) ? op_bad : opc;
  rt_use = (opc >= 4'd1) && (opc <= 4'd8);
  port = port_none;
  if (opc >= 4'd1 && opc <= 4'd7) begin
    port = port_alu;
  end else if (opc == 4'd8 || opc == 4'd9) begin
    port = port_mem;
  end else if (opc == 4'd10 || opc == 4'd11) begin
    port = port_branch;
  end
  use_const = 1'b1;
  case (opc)
    4'd6, 4'd8, 4'd9, 4'd10: cval = {{12{instr[3]}}, instr[3:0]};
    4'd7: cval = {{8{instr[7]}}, instr[7:0]};
    4'd11: cval = {{4{instr[11]}}, instr[11:0]};
    default: begin
      use_const = 1'b0;
      cval = '0;
    end
  endcase
  return {op, port, instr[11:8], instr[7:4], instr[3:0], rt_use, use_const, cval};
endfunction

task automatic advance_cycle(input logic f_en, input logic f_thread, input logic [15:0] f_instr,
                             input logic x_en, input logic x_thread, input logic [15:0] x_ip,
                             input logic hold);
  logic [1:0] hv [2];
  logic       jmp;
  logic       flushing;
  logic       accept;
  logic       nthread;
  int         npop;
  for (int t = 0; t < 2; t++) begin
    flushing = x_en && (x_thread == t);
    hv[t][0] = (mcount[t] >= 1) && !flushing;
    hv[t][1] = (mcount[t] >= 2) && !flushing;
  end
  jmp = (mq[mthread][0][15:12] == 4'd11);
  exp_en[0] = hv[mthread][0] && !hold;
  exp_en[1] = hv[mthread][1] && !hold && !jmp;
  exp_thread = mthread;
  exp_ip[0] = mip[mthread];
  exp_ip[1] = mip[mthread] + 16'd1;
  exp_instr[0] = mq[mthread][0];
  exp_instr[1] = mq[mthread][1];
  npop = int'(exp_en[0]) + int'(exp_en[1]);
  // lone ready thread wins, else alternate
  if (hv[0][0] && !hv[1][0]) nthread = 1'b0;
  else if (hv[1][0] && !hv[0][0]) nthread = 1'b1;
  else nthread = !mthread;
  for (int t = 0; t < 2; t++) begin
    flushing = x_en && (x_thread == t);
    accept = flushing || (mcount[t] < depth);
    if (flushing) begin
      mcount[t] = 0;
      mip[t] = x_ip;
    end else if (t == mthread) begin
      repeat (npop) begin
        for (int i = 0; i < depth - 1; i++) begin
          mq[t][i] = mq[t][i + 1];
        end
      end
      mcount[t] = mcount[t] - npop;
      mip[t] = mip[t] + 16'(npop);
    end
    if (f_en && (f_thread == t)) begin
      if (accept) begin
        mq[t][mcount[t]] = f_instr;
        mcount[t] = mcount[t] + 1;
      end else begin
        lost_fills = lost_fills + 1;
      end
    end
  end
  mthread = nthread;
endtask

//--- verification/tb_fetch_top.sv
module tb_fetch_top;
  import fetch_pkg::*;

  localparam int reset_cycles  = 8;
  localparam int random_cycles = 3000;
  localparam int fill_cycles   = 12;
  localparam int drain_cycles  = 16;
  localparam int total_cycles  = reset_cycles + random_cycles + fill_cycles + drain_cycles;

  logic              clk;
  logic              rst;
  logic              fill_en;
  logic              fill_thread;
  logic [instr_w-1:0] fill_instr;
  logic              except;
  logic              except_thread;
  logic [ip_w-1:0]   except_ip;
  logic              stall;
  logic [1:0]        full;
  logic              bundle_feed;
  logic              slot0_en;
  logic              slot0_thread;
  logic              slot0_rt_use;
  logic              slot0_use_const;
  logic [ip_w-1:0]   slot0_ip;
  op_e               slot0_op;
  port_e             slot0_port;
  logic [reg_w-1:0]  slot0_rt;
  logic [reg_w-1:0]  slot0_ra;
  logic [reg_w-1:0]  slot0_rb;
  logic [data_w-1:0] slot0_const;
  logic              slot1_en;
  logic              slot1_thread;
  logic              slot1_rt_use;
  logic              slot1_use_const;
  logic [ip_w-1:0]   slot1_ip;
  op_e               slot1_op;
  port_e             slot1_port;
  logic [reg_w-1:0]  slot1_rt;
  logic [reg_w-1:0]  slot1_ra;
  logic [reg_w-1:0]  slot1_rb;
  logic [data_w-1:0] slot1_const;

  integer seed;
  int     checks;
  int     errors;
  int     checks_mark;
  int     errors_mark;
  int     lost_before;
  int     refused_fills;
  logic   prev_stall;

  `include "fetch_model.svh"

  fetch_top #(.queue_depth(depth)) dut0 (.*);

  bind fetch_top fetch_assertions assert0 (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .slot0_en (slot0_en),
    .slot1_en (slot1_en),
    .slot0_op (slot0_op)
  );

  always #5 clk = ~clk;

  task automatic check_slot(input int n, input logic en, input logic thread,
                            input logic [15:0] ip, input logic [3:0] op, input logic [1:0] port,
                            input logic [3:0] rt, input logic [3:0] ra, input logic [3:0] rb,
                            input logic rt_use, input logic use_const, input logic [15:0] cval);
    logic [52:0] got;
    logic [52:0] want;
    checks++;
    assert (en === exp_en[n]) else begin
      errors++;
      $display("mismatch at %0t: slot%0d enable %b, model %b", $time, n, en, exp_en[n]);
    end
    if (en && exp_en[n]) begin
      got = {thread, ip, op, port, rt, ra, rb, rt_use, use_const, cval};
      want = {exp_thread, exp_ip[n], decode_fields(exp_instr[n])};
      checks++;
      assert (got === want) else begin
        errors++;
        $display("mismatch at %0t: slot%0d fields %h, model %h", $time, n, got, want);
      end
    end
  endtask

  task automatic check_outputs();
    check_slot(0, slot0_en, slot0_thread, slot0_ip, slot0_op, slot0_port, slot0_rt,
               slot0_ra, slot0_rb, slot0_rt_use, slot0_use_const, slot0_const);
    check_slot(1, slot1_en, slot1_thread, slot1_ip, slot1_op, slot1_port, slot1_rt,
               slot1_ra, slot1_rb, slot1_rt_use, slot1_use_const, slot1_const);
    checks++;
    assert (full === {mcount[1] == depth, mcount[0] == depth}) else begin
      errors++;
      $display("mismatch at %0t: full %b, model counts %0d %0d", $time, full,
               mcount[0], mcount[1]);
    end
    checks++;
    assert (bundle_feed === exp_en[0]) else begin
      errors++;
      $display("mismatch at %0t: bundle_feed %b, model %b", $time, bundle_feed, exp_en[0]);
    end
    if (prev_stall) begin
      checks++;
      assert (!slot0_en && !slot1_en) else begin
        errors++;
        $display("slot issued at %0t in the cycle after a stall", $time);
      end
    end
  endtask

  // inputs already driven, model steps, then the registered result is checked
  task automatic step_and_check();
    advance_cycle(fill_en, fill_thread, fill_instr, except, except_thread, except_ip, stall);
    prev_stall = stall;
    @(posedge clk);
    #1;
    check_outputs();
  endtask

  task automatic drive_idle();
    fill_en = 1'b0;
    fill_thread = 1'b0;
    fill_instr = '0;
    except = 1'b0;
    except_thread = 1'b0;
    except_ip = '0;
    stall = 1'b0;
  endtask

  task automatic drive_random();
    fill_en = ({$random(seed)} % 100) < 85;
    fill_thread = 1'($random(seed));
    fill_instr = 16'($random(seed));
    except = ({$random(seed)} % 100) < 2;
    except_thread = 1'($random(seed));
    except_ip = 16'($random(seed));
    stall = ({$random(seed)} % 100) < 10;
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  initial begin
    seed = 84388;
    checks = 0;
    errors = 0;
    checks_mark = 0;
    errors_mark = 0;
    prev_stall = 1'b0;
    clk = 1'b0;
    rst = 1'b1;
    drive_idle();
    clear_state();
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    check_outputs();
    finish_test("reset");

    for (int c = 0; c < random_cycles; c++) begin
      drive_random();
      step_and_check();
    end
    finish_test("random");

    // redirect thread 0, then overfill it while stalled
    lost_before = lost_fills;
    refused_fills = 0;
    for (int c = 0; c < fill_cycles; c++) begin
      fill_en = 1'b1;
      fill_thread = 1'b0;
      fill_instr = 16'($random(seed));
      except = (c == 0);
      except_thread = 1'b0;
      except_ip = 16'h2000;
      stall = 1'b1;
      // fill offered to a full queue outside a redirect
      if (full[0] && !except) begin
        refused_fills++;
      end
      step_and_check();
    end
    checks++;
    assert (full[0] === 1'b1) else begin
      errors++;
      $display("thread 0 queue did not report full after %0d fills", fill_cycles);
    end
    checks++;
    assert (refused_fills == lost_fills - lost_before) else begin
      errors++;
      $display("mismatch at %0t: %0d fills offered while full, model lost %0d", $time,
               refused_fills, lost_fills - lost_before);
    end
    drive_idle();
    for (int c = 0; c < drain_cycles; c++) begin
      step_and_check();
    end
    finish_test("fill to full");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #((total_cycles + 100) * 10);
    $display("watchdog: run did not finish within its cycle budget");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- verification/fetch_assertions.sv
module fetch_assertions (
  input logic           clk,
  input logic           rst,
  input logic           stall,
  input logic           slot0_en,
  input logic           slot1_en,
  input fetch_pkg::op_e slot0_op
);
  import fetch_pkg::*;

  slot1_needs_slot0: assert property (@(posedge clk) disable iff (rst)
    slot1_en |-> slot0_en) else $error("slot1 issued without slot0");

  // a jump ends the bundle
  jmp_alone: assert property (@(posedge clk) disable iff (rst)
    (slot0_en && slot0_op == op_jmp) |-> !slot1_en) else $error("slot1 issued after jmp");

  stall_blocks_issue: assert property (@(posedge clk) disable iff (rst)
    stall |=> !slot0_en && !slot1_en) else $error("issue in the cycle after stall");

endmodule

//--- src/fetch_top.sv
module fetch_top #(
  parameter int queue_depth = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fill_en,
  input  logic                         fill_thread,
  input  logic [fetch_pkg::instr_w-1:0] fill_instr,
  input  logic                         except,
  input  logic                         except_thread,
  input  logic [fetch_pkg::ip_w-1:0]    except_ip,
  input  logic                         stall,
  output logic [1:0]                   full,
  output logic                         bundle_feed,
  output logic                         slot0_en,
  output logic                         slot0_thread,
  output logic [fetch_pkg::ip_w-1:0]    slot0_ip,
  output fetch_pkg::op_e               slot0_op,
  output fetch_pkg::port_e             slot0_port,
  output logic [fetch_pkg::reg_w-1:0]   slot0_rt,
  output logic [fetch_pkg::reg_w-1:0]   slot0_ra,
  output logic [fetch_pkg::reg_w-1:0]   slot0_rb,
  output logic                         slot0_rt_use,
  output logic                         slot0_use_const,
  output logic [fetch_pkg::data_w-1:0]  slot0_const,
  output logic                         slot1_en,
  output logic                         slot1_thread,
  output logic [fetch_pkg::ip_w-1:0]    slot1_ip,
  output fetch_pkg::op_e               slot1_op,
  output fetch_pkg::port_e             slot1_port,
  output logic [fetch_pkg::reg_w-1:0]   slot1_rt,
  output logic [fetch_pkg::reg_w-1:0]   slot1_ra,
  output logic [fetch_pkg::reg_w-1:0]   slot1_rb,
  output logic                         slot1_rt_use,
  output logic                         slot1_use_const,
  output logic [fetch_pkg::data_w-1:0]  slot1_const
);
  import fetch_pkg::*;

  logic [1:0]         fill_sel;
  logic [1:0]         flush_sel;
  logic [1:0]         head_valid0;
  logic [1:0]         head_valid1;
  logic [instr_w-1:0] head0_t0;
  logic [instr_w-1:0] head1_t0;
  logic [instr_w-1:0] head0_t1;
  logic [instr_w-1:0] head1_t1;
  logic [ip_w-1:0]    head_ip0;
  logic [ip_w-1:0]    head_ip1;
  logic [1:0]         pop0;
  logic [1:0]         pop1;
  logic [1:0]         sel_valid;
  logic [instr_w-1:0] sel_instr0;
  logic [instr_w-1:0] sel_instr1;
  logic [ip_w-1:0]    sel_ip;
  logic               sel_thread;

  // steer fill and redirect to their thread
  assign fill_sel  = {fill_en && fill_thread, fill_en && !fill_thread};
  assign flush_sel = {except && except_thread, except && !except_thread};

  thread_queue #(.queue_depth(queue_depth)) queue0 (
    .clk        (clk),
    .rst        (rst),
    .fill_en    (fill_sel[0]),
    .fill_instr (fill_instr),
    .flush      (flush_sel[0]),
    .flush_ip   (except_ip),
    .pop        (pop0),
    .full       (full[0]),
    .head_valid (head_valid0),
    .head0      (head0_t0),
    .head1      (head1_t0),
    .head_ip    (head_ip0)
  );

  thread_queue #(.queue_depth(queue_depth)) queue1 (
    .clk        (clk),
    .rst        (rst),
    .fill_en    (fill_sel[1]),
    .fill_instr (fill_instr),
    .flush      (flush_sel[1]),
    .flush_ip   (except_ip),
    .pop        (pop1),
    .full       (full[1]),
    .head_valid (head_valid1),
    .head0      (head0_t1),
    .head1      (head1_t1),
    .head_ip    (head_ip1)
  );

  thread_arbiter arbiter (.*);

  bundle_decoder decoder (.*);

endmodule

//--- src/bundle_decoder.sv
module bundle_decoder (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [1:0]                   sel_valid,
  input  logic [fetch_pkg::instr_w-1:0] sel_instr0,
  input  logic [fetch_pkg::instr_w-1:0] sel_instr1,
  input  logic [fetch_pkg::ip_w-1:0]    sel_ip,
  input  logic                         sel_thread,
  output logic                         bundle_feed,
  output logic                         slot0_en,
  output logic                         slot0_thread,
  output logic [fetch_pkg::ip_w-1:0]    slot0_ip,
  output fetch_pkg::op_e               slot0_op,
  output fetch_pkg::port_e             slot0_port,
  output logic [fetch_pkg::reg_w-1:0]   slot0_rt,
  output logic [fetch_pkg::reg_w-1:0]   slot0_ra,
  output logic [fetch_pkg::reg_w-1:0]   slot0_rb,
  output logic                         slot0_rt_use,
  output logic                         slot0_use_const,
  output logic [fetch_pkg::data_w-1:0]  slot0_const,
  output logic                         slot1_en,
  output logic                         slot1_thread,
  output logic [fetch_pkg::ip_w-1:0]    slot1_ip,
  output fetch_pkg::op_e               slot1_op,
  output fetch_pkg::port_e             slot1_port,
  output logic [fetch_pkg::reg_w-1:0]   slot1_rt,
  output logic [fetch_pkg::reg_w-1:0]   slot1_ra,
  output logic [fetch_pkg::reg_w-1:0]   slot1_rb,
  output logic                         slot1_rt_use,
  output logic                         slot1_use_const,
  output logic [fetch_pkg::data_w-1:0]  slot1_const
);
  import fetch_pkg::*;

  op_e              dec_op [2];
  port_e            dec_port [2];
  logic [reg_w-1:0] dec_rt [2];
  logic [reg_w-1:0] dec_ra [2];
  logic [reg_w-1:0] dec_rb [2];
  logic             dec_rt_use [2];
  logic             dec_use_const [2];
  logic [data_w-1:0] dec_const [2];

  slot_decoder dec0 (
    .instr     (sel_instr0),
    .op        (dec_op[0]),
    .port      (dec_port[0]),
    .rt        (dec_rt[0]),
    .ra        (dec_ra[0]),
    .rb        (dec_rb[0]),
    .rt_use    (dec_rt_use[0]),
    .use_const (dec_use_const[0]),
    .const_val (dec_const[0])
  );

  slot_decoder dec1 (
    .instr     (sel_instr1),
    .op        (dec_op[1]),
    .port      (dec_port[1]),
    .rt        (dec_rt[1]),
    .ra        (dec_ra[1]),
    .rb        (dec_rb[1]),
    .rt_use    (dec_rt_use[1]),
    .use_const (dec_use_const[1]),
    .const_val (dec_const[1])
  );

  assign bundle_feed = slot0_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      slot0_en <= 1'b0;
      slot1_en <= 1'b0;
    end else begin
      slot0_en <= sel_valid[0];
      slot1_en <= sel_valid[1];
    end
  end

  always_ff @(posedge clk) begin
    slot0_thread    <= sel_thread;
    slot0_ip        <= sel_ip;
    slot0_op        <= dec_op[0];
    slot0_port      <= dec_port[0];
    slot0_rt        <= dec_rt[0];
    slot0_ra        <= dec_ra[0];
    slot0_rb        <= dec_rb[0];
    slot0_rt_use    <= dec_rt_use[0];
    slot0_use_const <= dec_use_const[0];
    slot0_const     <= dec_const[0];
    // second slot sits one instruction further on
    slot1_thread    <= sel_thread;
    slot1_ip        <= sel_ip + ip_w'(1);
    slot1_op        <= dec_op[1];
    slot1_port      <= dec_port[1];
    slot1_rt        <= dec_rt[1];
    slot1_ra        <= dec_ra[1];
    slot1_rb        <= dec_rb[1];
    slot1_rt_use    <= dec_rt_use[1];
    slot1_use_const <= dec_use_const[1];
    slot1_const     <= dec_const[1];
  end

endmodule

//--- src/slot_decoder.sv
module slot_decoder (
  input  logic [fetch_pkg::instr_w-1:0] instr,
  output fetch_pkg::op_e               op,
  output fetch_pkg::port_e             port,
  output logic [fetch_pkg::reg_w-1:0]   rt,
  output logic [fetch_pkg::reg_w-1:0]   ra,
  output logic [fetch_pkg::reg_w-1:0]   rb,
  output logic                         rt_use,
  output logic                         use_const,
  output logic [fetch_pkg::data_w-1:0]  const_val
);
  import fetch_pkg::*;

  opcode_e           opc;
  logic [data_w-1:0] imm4;
  logic [data_w-1:0] imm8;
  logic [data_w-1:0] imm12;

  assign opc = opcode_e'(instr[instr_w-1 -: $bits(opcode_e)]);
  assign rt  = instr[11:8];
  assign ra  = instr[7:4];
  assign rb  = instr[3:0];

  assign imm4  = {{(data_w - 4){instr[3]}}, instr[3:0]};
  assign imm8  = {{(data_w - 8){instr[7]}}, instr[7:0]};
  assign imm12 = {{(data_w - 12){instr[11]}}, instr[11:0]};

  // defined codes keep their value in op_e
  assign op = (opc > opc_jmp) ? op_bad : op_e'(opc);

  always_comb begin
    port      = port_none;
    rt_use    = 1'b0;
    use_const = 1'b0;
    const_val = '0;
    case (opc)
      opc_add, opc_sub, opc_and, opc_or, opc_xor: begin
        port   = port_alu;
        rt_use = 1'b1;
      end
      opc_addi, opc_ldi: begin
        port      = port_alu;
        rt_use    = 1'b1;
        use_const = 1'b1;
        const_val = (opc == opc_ldi) ? imm8 : imm4;
      end
      opc_ld, opc_st: begin
        port      = port_mem;
        rt_use    = (opc == opc_ld);
        use_const = 1'b1;
        const_val = imm4;
      end
      opc_beq, opc_jmp: begin
        port      = port_branch;
        use_const = 1'b1;
        const_val = (opc == opc_jmp) ? imm12 : imm4;
      end
      default: begin
        port = port_none;
      end
    endcase
  end

endmodule

//--- src/thread_arbiter.sv
module thread_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         stall,
  input  logic [1:0]                   head_valid0,
  input  logic [1:0]                   head_valid1,
  input  logic [fetch_pkg::instr_w-1:0] head0_t0,
  input  logic [fetch_pkg::instr_w-1:0] head1_t0,
  input  logic [fetch_pkg::instr_w-1:0] head0_t1,
  input  logic [fetch_pkg::instr_w-1:0] head1_t1,
  input  logic [fetch_pkg::ip_w-1:0]    head_ip0,
  input  logic [fetch_pkg::ip_w-1:0]    head_ip1,
  output logic [1:0]                   pop0,
  output logic [1:0]                   pop1,
  output logic [1:0]                   sel_valid,
  output logic [fetch_pkg::instr_w-1:0] sel_instr0,
  output logic [fetch_pkg::instr_w-1:0] sel_instr1,
  output logic [fetch_pkg::ip_w-1:0]    sel_ip,
  output logic                         sel_thread
);
  import fetch_pkg::*;

  logic       thread;
  logic [1:0] cur_valid;
  logic       head0_jmp;
  logic [1:0] pop_cnt;

  assign cur_valid  = thread ? head_valid1 : head_valid0;
  assign sel_instr0 = thread ? head0_t1 : head0_t0;
  assign sel_instr1 = thread ? head1_t1 : head1_t0;
  assign sel_ip     = thread ? head_ip1 : head_ip0;
  assign sel_thread = thread;

  // a jump closes the pair
  assign head0_jmp = (sel_instr0[instr_w-1 -: $bits(opcode_e)] == opc_jmp);

  assign sel_valid[0] = cur_valid[0] && !stall;
  assign sel_valid[1] = cur_valid[1] && !stall && !head0_jmp;

  assign pop_cnt = {1'b0, sel_valid[0]} + {1'b0, sel_valid[1]};
  assign pop0    = thread ? 2'd0 : pop_cnt;
  assign pop1    = thread ? pop_cnt : 2'd0;

  // a lone ready thread wins, otherwise alternate
  always_ff @(posedge clk) begin
    if (rst) begin
      thread <= 1'b0;
    end else if (head_valid0[0] && !head_valid1[0]) begin
      thread <= 1'b0;
    end else if (head_valid1[0] && !head_valid0[0]) begin
      thread <= 1'b1;
    end else begin
      thread <= !thread;
    end
  end

endmodule

//--- src/thread_queue.sv
module thread_queue #(
  parameter int queue_depth = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fill_en,
  input  logic [fetch_pkg::instr_w-1:0] fill_instr,
  input  logic                         flush,
  input  logic [fetch_pkg::ip_w-1:0]    flush_ip,
  input  logic [1:0]                   pop,
  output logic                         full,
  output logic [1:0]                   head_valid,
  output logic [fetch_pkg::instr_w-1:0] head0,
  output logic [fetch_pkg::instr_w-1:0] head1,
  output logic [fetch_pkg::ip_w-1:0]    head_ip
);
  import fetch_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  logic [instr_w-1:0] mem [queue_depth];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [cnt_w-1:0]   count;
  logic [ip_w-1:0]    ip;
  logic               do_fill;
  logic [ptr_w-1:0]   wr_addr;

  // pointer advance with wrap at the queue depth
  function automatic logic [ptr_w-1:0] ptr_add(input logic [ptr_w-1:0] p,
                                               input logic [1:0] n);
    logic [ptr_w+1:0] sum;
    sum = (ptr_w + 2)'(p) + (ptr_w + 2)'(n);
    if (sum >= (ptr_w + 2)'(queue_depth)) begin
      sum = sum - (ptr_w + 2)'(queue_depth);
    end
    return sum[ptr_w-1:0];
  endfunction

  assign full = (count == cnt_w'(queue_depth));

  // a flushing queue hides its old entries
  assign head_valid[0] = (count >= cnt_w'(1)) && !flush;
  assign head_valid[1] = (count >= cnt_w'(2)) && !flush;

  assign head0   = mem[rd_ptr];
  assign head1   = mem[ptr_add(rd_ptr, 2'd1)];
  assign head_ip = ip;

  // fill during a flush lands in the first slot
  assign do_fill = fill_en && (flush || !full);
  assign wr_addr = flush ? '0 : wr_ptr;

  always_ff @(posedge clk) begin
    if (do_fill) begin
      mem[wr_addr] <= fill_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      ip     <= init_ip;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= fill_en ? ptr_w'(1) : '0;
      count  <= cnt_w'(fill_en);
      ip     <= flush_ip;
    end else begin
      rd_ptr <= ptr_add(rd_ptr, pop);
      wr_ptr <= ptr_add(wr_ptr, {1'b0, do_fill});
      count  <= count + cnt_w'(do_fill) - cnt_w'(pop);
      ip     <= ip + ip_w'(pop);
    end
  end

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

  // instruction layout: opcode [15:12], rt [11:8], ra [7:4], rb or imm [3:0]
  parameter int instr_w = 16;
  parameter int ip_w    = 16;
  parameter int reg_w   = 4;
  parameter int data_w  = 16;

  parameter logic [ip_w-1:0] init_ip = 16'h0100;

  // raw opcodes, 12 to 15 undefined
  typedef enum logic [3:0] {
    opc_nop  = 4'd0,
    opc_add  = 4'd1,
    opc_sub  = 4'd2,
    opc_and  = 4'd3,
    opc_or   = 4'd4,
    opc_xor  = 4'd5,
    opc_addi = 4'd6,
    opc_ldi  = 4'd7,
    opc_ld   = 4'd8,
    opc_st   = 4'd9,
    opc_beq  = 4'd10,
    opc_jmp  = 4'd11
  } opcode_e;

  // decoded operation, same order as the raw opcodes
  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_addi,
    op_ldi,
    op_ld,
    op_st,
    op_beq,
    op_jmp,
    op_bad
  } op_e;

  typedef enum logic [1:0] {
    port_none,
    port_alu,
    port_mem,
    port_branch
  } port_e;

endpackage
